// File: lsu.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_ctrl.sv
verilog/lsu_read_port.sv
verilog/lsu_write_port.sv
verilog/lsu_wb_sel.sv
verilog/lsu.sv
testbench/tb_axi_mem.sv
testbench/tb_lsu.sv

// File: run_lsu.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f lsu.f -o sim_lsu
./obj_dir/sim_lsu > sim_lsu.log 2>&1 || true
cat sim_lsu.log

if grep -q "FAIL: see errors above" sim_lsu.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "PASS: all tests" sim_lsu.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: testbench/tb_axi_mem.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module tb_axi_mem
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   arvalid,
  output logic                   arready,
  input  axi_ar_t                ar,
  output logic                   rvalid,
  input  logic                   rready,
  output axi_r_t                 r,
  input  logic                   awvalid,
  output logic                   awready,
  input  axi_aw_t                aw,
  input  logic                   wvalid,
  output logic                   wready,
  input  axi_w_t                 w,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [`LSU_RESP_W-1:0] bresp
);

  logic [`LSU_XLEN-1:0] mem [256];
  integer               seed = 96;
  logic [1:0]           ar_dly, r_dly, aw_dly, w_dly, b_dly;
  logic                 r_pend, aw_got, w_got;
  logic [`LSU_XLEN-1:0] ar_addr;
  axi_aw_t              aw_q;
  axi_w_t               w_q;

  function automatic logic [1:0] next_delay();
    logic [31:0] v;
    v = $random(seed);
    return v[1:0];
  endfunction

  initial begin
    arready <= 1'b0;
    rvalid  <= 1'b0;
    r       <= '0;
    awready <= 1'b0;
    wready  <= 1'b0;
    bvalid  <= 1'b0;
    bresp   <= '0;
    // every byte depends on the full word index
    for (int i = 0; i < 256; i++) begin
      mem[i] <= {~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c, i[7:0]};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      r_pend  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      ar_dly  <= next_delay();
      r_dly   <= next_delay();
      aw_dly  <= next_delay();
      w_dly   <= next_delay();
      b_dly   <= next_delay();
    end else begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_addr <= ar.addr;
        r_pend  <= 1'b1;
      end else if (arvalid && !r_pend && !rvalid) begin
        arready <= (ar_dly == 2'd0);
        ar_dly  <= ar_dly - 2'd1;
      end
      // bit 10 marks the error region, data reads as zero there
      if (r_pend && !rvalid) begin
        r_dly <= r_dly - 2'd1;
        if (r_dly == 2'd0) begin
          rvalid <= 1'b1;
          r_pend <= 1'b0;
          r.data <= ar_addr[10] ? '0 : mem[ar_addr[9:2]];
          r.resp <= ar_addr[10] ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        ar_dly <= next_delay();
        r_dly  <= next_delay();
      end

      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_q    <= aw;
        aw_got  <= 1'b1;
      end else if (awvalid && !aw_got) begin
        awready <= (aw_dly == 2'd0);
        aw_dly  <= aw_dly - 2'd1;
      end
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_q    <= w;
        w_got  <= 1'b1;
      end else if (wvalid && !w_got) begin
        wready <= (w_dly == 2'd0);
        w_dly  <= w_dly - 2'd1;
      end
      // respond once address and data are both in
      if (aw_got && w_got && !bvalid) begin
        b_dly <= b_dly - 2'd1;
        if (b_dly == 2'd0) begin
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
          bresp  <= aw_q.addr[10] ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
          for (int b = 0; b < `LSU_STRB_W; b++) begin
            if (w_q.strb[b] && !aw_q.addr[10]) begin
              mem[aw_q.addr[9:2]][8*b +: 8] <= w_q.data[8*b +: 8];
            end
          end
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_dly <= next_delay();
        w_dly  <= next_delay();
        b_dly  <= next_delay();
      end
    end
  end

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module tb_lsu
  import lsu_pkg::*;
();

  localparam int CLK_NS      = 4;
  localparam int N_STORE     = 24;
  // store and read-back pairs, load sweep, non-memory ops, error cases
  localparam int N_REQ       = 2 * N_STORE + 14 + 8 + 3;
  localparam int WATCHDOG_NS = (10 + 40 * N_REQ) * CLK_NS;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   in_valid;
  lsu_req_t               in_req;
  logic                   busy;
  logic                   out_valid;
  lsu_wb_t                out_wb;
  logic                   arvalid, arready, rvalid, rready;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;
  axi_ar_t                ar;
  axi_r_t                 r;
  axi_aw_t                aw;
  axi_w_t                 w;
  logic [`LSU_RESP_W-1:0] bresp;

  integer               seed = 96;
  logic [`LSU_XLEN-1:0] shadow [256];
  logic [`LSU_XLEN-1:0] last_rdata = '0;
  lsu_wb_t              exp_q [$];
  int                   lat_q [$];
  int                   cyc = 0;
  int                   accept_cyc = 0;
  lsu_wb_t              last_wb;
  logic                 hold = 1'b0;
  logic                 busy_exp = 1'b0;

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  lsu i_lsu (.*);

  tb_axi_mem i_mem (.*);

  function automatic lsu_wb_t expect_wb(input lsu_req_t req);
    lsu_wb_t              wb;
    logic [1:0]           off;
    logic [7:0]           b;
    logic [15:0]          h;
    logic [`LSU_XLEN-1:0] ld;
    off = req.alu_result[1:0];
    b   = last_rdata[8*off +: 8];
    h   = last_rdata[16*off[1] +: 16];
    case (req.size)
      MEM_BYTE: ld = {{24{req.load_signed & b[7]}}, b};
      MEM_HALF: ld = {{16{req.load_signed & h[15]}}, h};
      default:  ld = last_rdata;
    endcase
    wb = '0;
    case (req.wd_sel)
      WD_ALU:  wb.wd = req.alu_result;
      WD_LOAD: wb.wd = ld;
      WD_PC4:  wb.wd = req.pc + 32'd4;
      default: wb.wd = req.src2;
    endcase
    wb.csr_wd       = (req.csr_wd_sel == CSR_WD_PC) ? req.pc : req.alu_result;
    wb.rd           = req.rd;
    wb.csr_rd       = req.csr_rd;
    wb.reg_we       = req.reg_we;
    wb.csr_we       = req.csr_we;
    wb.ecall        = req.ecall;
    wb.access_fault = (req.ren || req.wen) && req.alu_result[10];
    return wb;
  endfunction

  // random non-memory request at an aligned word in the normal region
  function automatic lsu_req_t base_req();
    lsu_req_t    q;
    logic [31:0] v;
    q            = '0;
    q.pc         = $random(seed);
    q.src2       = $random(seed);
    v            = $random(seed);
    q.rd         = v[4:0];
    q.csr_rd     = v[6:5];
    q.reg_we     = v[7];
    q.csr_we     = v[8];
    q.ecall      = v[9];
    q.csr_wd_sel = csr_wd_sel_e'(v[10]);
    q.alu_result = {21'h0, 1'b0, v[20:13], 2'b00};
    return q;
  endfunction

  task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic issue(input lsu_req_t req);
    logic [7:0] idx;
    idx = req.alu_result[9:2];
    if (req.wen && !req.alu_result[10]) begin
      for (int b = 0; b < `LSU_STRB_W; b++) begin
        if (req.wstrb[b]) begin
          shadow[idx][8*b +: 8] = req.src2[8*b +: 8];
        end
      end
    end
    if (req.ren) begin
      last_rdata = req.alu_result[10] ? '0 : shadow[idx];
    end
    exp_q.push_back(expect_wb(req));
    lat_q.push_back((req.ren || req.wen) ? 0 : 2);
    do begin
      @(negedge clk);
    end while (busy);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= req;
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  always @(negedge clk) begin : compare
    lsu_wb_t exp_wb;
    int      lat;
    if (!rst) begin
      if (out_valid) begin
        busy_exp = 1'b0;
        if (exp_q.size() == 0) begin
          $display("out_valid at %0t with no request outstanding", $time);
          $display("FAIL: see errors above");
          $fatal(1, "unexpected completion");
        end else begin
          exp_wb = exp_q.pop_front();
          lat    = lat_q.pop_front();
          check("out_wb", 96'(out_wb), 96'(exp_wb));
          if (lat != 0) begin
            check("accept_to_out_valid", 96'(cyc - accept_cyc), 96'(lat));
          end
          last_wb = out_wb;
          hold    = 1'b1;
        end
      end else if (hold) begin
        check("out_wb_hold", 96'(out_wb), 96'(last_wb));
      end
      // busy rises after each accept and falls with out_valid
      check("busy", 96'(busy), 96'(busy_exp));
      if (in_valid && !busy) begin
        accept_cyc = cyc;
        hold       = 1'b0;
        busy_exp   = 1'b1;
      end
    end
  end

  initial begin
    lsu_req_t    req;
    logic [31:0] v;
    rst      <= 1'b1;
    in_valid <= 1'b0;
    in_req   <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = i_mem.mem[i];
    end

    // strobed stores followed by full-word read back
    repeat (N_STORE) begin
      req      = base_req();
      v        = $random(seed);
      req.wen  = 1'b1;
      req.size = (v[1:0] == 2'd0) ? MEM_BYTE : (v[1:0] == 2'd1) ? MEM_HALF : MEM_WORD;
      case (req.size)
        MEM_BYTE: req.wstrb = 4'b0001 << v[3:2];
        MEM_HALF: req.wstrb = v[3] ? 4'b1100 : 4'b0011;
        default:  req.wstrb = 4'b1111;
      endcase
      issue(req);
      req.wen    = 1'b0;
      req.ren    = 1'b1;
      req.size   = MEM_WORD;
      req.wd_sel = WD_LOAD;
      issue(req);
    end

    // every size, aligned offset and sign
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        for (int sg = 0; sg < 2; sg++) begin
          if (off % (1 << s) == 0) begin
            req                 = base_req();
            req.ren             = 1'b1;
            req.size            = mem_size_e'(s[1:0]);
            req.load_signed     = sg[0];
            req.alu_result[1:0] = off[1:0];
            req.wd_sel          = WD_LOAD;
            issue(req);
          end
        end
      end
    end

    for (int k = 0; k < 8; k++) begin
      req            = base_req();
      req.wd_sel     = wd_sel_e'(k[1:0]);
      req.csr_wd_sel = csr_wd_sel_e'(k[2]);
      issue(req);
    end

    // faulting load and store before a clean load
    req                = base_req();
    req.ren            = 1'b1;
    req.size           = MEM_WORD;
    req.wd_sel         = WD_LOAD;
    req.alu_result[10] = 1'b1;
    issue(req);
    req.ren   = 1'b0;
    req.wen   = 1'b1;
    req.wstrb = 4'b1111;
    issue(req);
    req.wen            = 1'b0;
    req.ren            = 1'b1;
    req.alu_result[10] = 1'b0;
    issue(req);

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: requests did not complete within %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

endmodule

// File: verilog/lsu.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  lsu_req_t               in_req,
  output logic                   busy,
  output logic                   out_valid,
  output lsu_wb_t                out_wb,
  output logic                   arvalid,
  input  logic                   arready,
  output axi_ar_t                ar,
  input  logic                   rvalid,
  output logic                   rready,
  input  axi_r_t                 r,
  output logic                   awvalid,
  input  logic                   awready,
  output axi_aw_t                aw,
  output logic                   wvalid,
  input  logic                   wready,
  output axi_w_t                 w,
  input  logic                   bvalid,
  output logic                   bready,
  input  logic [`LSU_RESP_W-1:0] bresp
);

  lsu_req_t             held_req;
  logic                 rd_start;
  logic                 wr_start;
  logic                 rd_done;
  logic                 rd_err;
  logic [`LSU_XLEN-1:0] rd_data;
  logic                 wr_done;
  logic                 wr_err;
  logic                 access_fault;

  lsu_ctrl i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_req       (in_req),
    .rd_done      (rd_done),
    .rd_err       (rd_err),
    .wr_done      (wr_done),
    .wr_err       (wr_err),
    .busy         (busy),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .held_req     (held_req),
    .out_valid    (out_valid),
    .access_fault (access_fault)
  );

  // ports take the request fields in the accept cycle
  lsu_read_port i_read_port (
    .clk      (clk),
    .rst      (rst),
    .rd_start (rd_start),
    .rd_addr  (in_req.alu_result),
    .arvalid  (arvalid),
    .arready  (arready),
    .ar       (ar),
    .rvalid   (rvalid),
    .rready   (rready),
    .r        (r),
    .rd_done  (rd_done),
    .rd_data  (rd_data),
    .rd_err   (rd_err)
  );

  lsu_write_port i_write_port (
    .clk      (clk),
    .rst      (rst),
    .wr_start (wr_start),
    .wr_addr  (in_req.alu_result),
    .wr_data  (in_req.src2),
    .wr_strb  (in_req.wstrb),
    .awvalid  (awvalid),
    .awready  (awready),
    .aw       (aw),
    .wvalid   (wvalid),
    .wready   (wready),
    .w        (w),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .wr_done  (wr_done),
    .wr_err   (wr_err)
  );

  lsu_wb_sel i_wb_sel (
    .held_req     (held_req),
    .rd_data      (rd_data),
    .access_fault (access_fault),
    .out_wb       (out_wb)
  );

endmodule

// File: verilog/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width
`define LSU_XLEN 32

// one strobe bit per data byte
`define LSU_STRB_W 4

`define LSU_RESP_W 2

// axi response codes
`define LSU_RESP_OKAY   2'b00
`define LSU_RESP_EXOKAY 2'b01
`define LSU_RESP_SLVERR 2'b10
`define LSU_RESP_DECERR 2'b11

`endif

// File: verilog/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  lsu_req_t in_req,
  input  logic     rd_done,
  input  logic     rd_err,
  input  logic     wr_done,
  input  logic     wr_err,
  output logic     busy,
  output logic     rd_start,
  output logic     wr_start,
  output lsu_req_t held_req,
  output logic     out_valid,
  output logic     access_fault
);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } state_e;

  state_e state;
  logic   accept;
  logic   done;
  logic   err;

  assign accept   = in_valid && (state == ST_IDLE);
  assign rd_start = accept && in_req.ren;
  assign wr_start = accept && in_req.wen;
  assign busy     = (state == ST_BUSY);

  // non-memory ops finish on the first busy cycle
  assign done = (state == ST_BUSY) &&
                ((!held_req.ren && !held_req.wen) || rd_done || wr_done);
  assign err  = (rd_done && rd_err) || (wr_done && wr_err);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      out_valid    <= 1'b0;
      access_fault <= 1'b0;
    end else begin
      out_valid <= done;
      if (state == ST_IDLE) begin
        if (accept) begin
          state <= ST_BUSY;
        end
      end else if (done) begin
        state        <= ST_IDLE;
        // held until the next completion
        access_fault <= err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_req <= in_req;
    end
  end

  // upstream must wait for busy to drop
  a_no_valid_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> !busy
  ) else $error("in_valid while busy");

  a_not_load_and_store: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> !(in_req.ren && in_req.wen)
  ) else $error("ren and wen set together");

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

  // access size, word is the widest
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_size_e;

  // register write-back source
  typedef enum logic [1:0] {
    WD_ALU  = 2'd0,
    WD_LOAD = 2'd1,
    WD_PC4  = 2'd2,
    WD_SRC2 = 2'd3
  } wd_sel_e;

  typedef enum logic {
    CSR_WD_ALU = 1'b0,
    CSR_WD_PC  = 1'b1
  } csr_wd_sel_e;

  // instruction bundle from execute
  typedef struct packed {
    logic                   ren;
    logic                   wen;
    logic                   load_signed;
    mem_size_e              size;
    logic [`LSU_STRB_W-1:0] wstrb;
    logic [`LSU_XLEN-1:0]   alu_result;
    logic [`LSU_XLEN-1:0]   pc;
    logic [`LSU_XLEN-1:0]   src2;
    wd_sel_e                wd_sel;
    csr_wd_sel_e            csr_wd_sel;
    logic [4:0]             rd;
    logic [1:0]             csr_rd;
    logic                   reg_we;
    logic                   csr_we;
    logic                   ecall;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] wd;
    logic [`LSU_XLEN-1:0] csr_wd;
    logic [4:0]           rd;
    logic [1:0]           csr_rd;
    logic                 reg_we;
    logic                 csr_we;
    logic                 ecall;
    logic                 access_fault;
  } lsu_wb_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_RESP_W-1:0] resp;
  } axi_r_t;

endpackage

// File: verilog/lsu_read_port.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_read_port
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_start,
  input  logic [`LSU_XLEN-1:0] rd_addr,
  output logic                 arvalid,
  input  logic                 arready,
  output axi_ar_t              ar,
  input  logic                 rvalid,
  output logic                 rready,
  input  axi_r_t               r,
  output logic                 rd_done,
  output logic [`LSU_XLEN-1:0] rd_data,
  output logic                 rd_err
);

  logic r_fire;

  assign r_fire = rvalid && rready;

  always_ff @(posedge clk) begin
    if (rst) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      // always ready for read data once out of reset
      rready  <= 1'b1;
      rd_done <= r_fire;
      if (rd_start) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) begin
      ar.addr <= rd_addr;
    end
  end

  // data and response captured together on the R beat
  always_ff @(posedge clk) begin
    if (r_fire) begin
      rd_data <= r.data;
      rd_err  <= (r.resp != `LSU_RESP_OKAY);
    end
  end

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    rd_start |-> !arvalid
  ) else $error("rd_start with AR still pending");

  a_ar_stable: assert property (
    @(posedge clk) disable iff (rst)
    (arvalid && !arready) |=> (arvalid && $stable(ar))
  ) else $error("AR channel changed before arready");

endmodule

// File: verilog/lsu_wb_sel.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_wb_sel
  import lsu_pkg::*;
(
  input  lsu_req_t             held_req,
  input  logic [`LSU_XLEN-1:0] rd_data,
  input  logic                 access_fault,
  output lsu_wb_t              out_wb
);

  localparam logic [`LSU_XLEN-1:0] INSN_BYTES = 4;

  logic [`LSU_XLEN-1:0] lane;
  logic [`LSU_XLEN-1:0] load_val;
  logic                 fill_b;
  logic                 fill_h;

  // low address bits select the byte lane
  assign lane   = rd_data >> {held_req.alu_result[1:0], 3'b000};
  assign fill_b = held_req.load_signed && lane[7];
  assign fill_h = held_req.load_signed && lane[15];

  always_comb begin
    case (held_req.size)
      MEM_BYTE: load_val = {{(`LSU_XLEN-8){fill_b}}, lane[7:0]};
      MEM_HALF: load_val = {{(`LSU_XLEN-16){fill_h}}, lane[15:0]};
      default:  load_val = lane;
    endcase
  end

  always_comb begin
    case (held_req.wd_sel)
      WD_ALU:  out_wb.wd = held_req.alu_result;
      WD_LOAD: out_wb.wd = load_val;
      WD_PC4:  out_wb.wd = held_req.pc + INSN_BYTES;
      default: out_wb.wd = held_req.src2;
    endcase
  end

  assign out_wb.csr_wd = (held_req.csr_wd_sel == CSR_WD_PC) ? held_req.pc
                                                            : held_req.alu_result;

  // destinations pass straight through
  assign out_wb.rd           = held_req.rd;
  assign out_wb.csr_rd       = held_req.csr_rd;
  assign out_wb.reg_we       = held_req.reg_we;
  assign out_wb.csr_we       = held_req.csr_we;
  assign out_wb.ecall        = held_req.ecall;
  assign out_wb.access_fault = access_fault;

endmodule

// File: verilog/lsu_write_port.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_write_port
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_start,
  input  logic [`LSU_XLEN-1:0]   wr_addr,
  input  logic [`LSU_XLEN-1:0]   wr_data,
  input  logic [`LSU_STRB_W-1:0] wr_strb,
  output logic                   awvalid,
  input  logic                   awready,
  output axi_aw_t                aw,
  output logic                   wvalid,
  input  logic                   wready,
  output axi_w_t                 w,
  input  logic                   bvalid,
  output logic                   bready,
  input  logic [`LSU_RESP_W-1:0] bresp,
  output logic                   wr_done,
  output logic                   wr_err
);

  logic b_fire;

  assign b_fire = bvalid && bready;

  always_ff @(posedge clk) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      bready  <= 1'b1;
      wr_done <= b_fire;
      // address and data channels retire on their own
      if (wr_start) begin
        awvalid <= 1'b1;
      end else if (awready) begin
        awvalid <= 1'b0;
      end
      if (wr_start) begin
        wvalid <= 1'b1;
      end else if (wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  // strobes and data go out as given, no lane shift
  always_ff @(posedge clk) begin
    if (wr_start) begin
      aw.addr <= wr_addr;
      w.data  <= wr_data;
      w.strb  <= wr_strb;
    end
  end

  always_ff @(posedge clk) begin
    if (b_fire) begin
      wr_err <= (bresp != `LSU_RESP_OKAY);
    end
  end

  a_aw_stable: assert property (
    @(posedge clk) disable iff (rst)
    (awvalid && !awready) |=> (awvalid && $stable(aw))
  ) else $error("AW channel changed before awready");

  a_w_stable: assert property (
    @(posedge clk) disable iff (rst)
    (wvalid && !wready) |=> (wvalid && $stable(w))
  ) else $error("W channel changed before wready");

endmodule
